// File: hdl/cop_macros.svh
`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

// Data path width of the coprocessor
`define COP_XLEN 32

// Coprocessor register count
`define COP_NREGS 16

// RISC-V custom-0 major opcode
`define COP_OPCODE 7'h0B

`endif

// File: hdl/cop_isa_pkg.sv
`include "cop_macros.svh"

package cop_isa_pkg;

  // Word carried on every data path (insn, operands, results)
  typedef logic [`COP_XLEN-1:0] cop_word_t;

  // Coprocessor register index
  typedef logic [$clog2(`COP_NREGS)-1:0] creg_idx_t;

  // Rotate amount, one full word
  typedef logic [$clog2(`COP_XLEN)-1:0] cop_shamt_t;

  // Operation in funct3, codes 6 and 7 unused
  typedef enum logic [2:0] {
    FN_G2C   = 3'd0, // GPR rs1 -> creg
    FN_C2G   = 3'd1, // creg -> GPR rd
    FN_XOR   = 3'd2,
    FN_ADD   = 3'd3,
    FN_ROR   = 3'd4, // Rotate right by immediate
    FN_BSWAP = 3'd5
  } cop_funct_e;

  // Field layout of a custom-0 coprocessor instruction
  //   [6:0]   opcode, custom-0
  //   [10:7]  coprocessor destination (GPR rd is [11:7], decoded by the CPU)
  //   [14:12] funct3
  //   [18:15] coprocessor source 1
  //   [23:20] coprocessor source 2
  //   [29:25] rotate amount
  localparam int OPC_LO    = 0;
  localparam int OPC_W     = 7;
  localparam int RD_LO     = 7;
  localparam int FUNCT3_LO = 12;
  localparam int RS1_LO    = 15;
  localparam int RS2_LO    = 20;
  localparam int SHAMT_LO  = 25;

endpackage

// File: hdl/cop_if_pkg.sv
package cop_if_pkg;

  // Outcome of one instruction, returned with the response
  typedef enum logic [2:0] {
    RES_OK       = 3'd0,
    RES_ILLEGAL  = 3'd1, // custom-0, unused funct3
    RES_NOT_MINE = 3'd2  // Not custom-0
  } cop_result_e;

  // Controller FSM
  typedef enum logic [1:0] {
    CS_IDLE, // Waiting for a request
    CS_EXEC, // Operand read and ALU
    CS_RSP   // Response held until acked
  } ctrl_state_e;

  // PCPI bridge FSM
  typedef enum logic [2:0] {
    BS_IDLE,
    BS_REQ,  // Request out to the controller
    BS_BUSY, // Waiting for the response
    BS_DONE, // Ready pulse
    BS_HOLD  // Wait for valid to fall
  } bridge_state_e;

endpackage

// File: hdl/cop_alu.sv
module cop_alu (
  input  cop_isa_pkg::cop_funct_e funct,
  input  cop_isa_pkg::cop_shamt_t shamt,
  input  cop_isa_pkg::cop_word_t  opa,
  input  cop_isa_pkg::cop_word_t  opb,
  output cop_isa_pkg::cop_word_t  res
);
  import cop_isa_pkg::*;

  localparam int W = $bits(cop_word_t);

  logic [2*W-1:0] ror_dbl; // opa twice, shifted
  cop_word_t      ror_res;
  cop_word_t      bswap_res;

  // Rotate as a shift of the doubled word
  assign ror_dbl = {opa, opa} >> shamt;
  assign ror_res = ror_dbl[W-1:0];

  // Byte order reversed
  assign bswap_res = {opa[7:0], opa[15:8], opa[23:16], opa[31:24]};

  always_comb begin
    case (funct)
      FN_G2C,
      FN_C2G:   res = opa; // Moves pass operand A
      FN_XOR:   res = opa ^ opb;
      FN_ADD:   res = opa + opb; // Carry out dropped
      FN_ROR:   res = ror_res;
      FN_BSWAP: res = bswap_res;
      default:  res = '0; // Unused funct3, result never written
    endcase
  end

endmodule

// File: hdl/cop_regfile.sv
`include "cop_macros.svh"

module cop_regfile (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cop_isa_pkg::creg_idx_t raddr1,
  input  cop_isa_pkg::creg_idx_t raddr2,
  output cop_isa_pkg::cop_word_t rdata1,
  output cop_isa_pkg::cop_word_t rdata2,
  input  logic                   wen,
  input  cop_isa_pkg::creg_idx_t waddr,
  input  cop_isa_pkg::cop_word_t wdata
);
  import cop_isa_pkg::*;

  cop_word_t regs [`COP_NREGS]; // All creg contents

  // Async reads, no bypass
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `COP_NREGS; i++) begin
        regs[i] <= '0; // All cregs read zero out of reset
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: hdl/cop_ctrl.sv
`include "cop_macros.svh"

module cop_ctrl (
  input  logic                    clk,
  input  logic                    arst_n,
  // Request from the bridge
  input  logic                    cpu_insn_req,
  input  cop_isa_pkg::cop_word_t  cpu_insn_enc,
  input  cop_isa_pkg::cop_word_t  cpu_rs1,
  output logic                    cop_insn_ack,
  // Response to the bridge
  output logic                    cop_insn_rsp,
  output logic                    cop_wen,
  output cop_isa_pkg::cop_word_t  cop_wdata,
  output cop_if_pkg::cop_result_e cop_result,
  input  logic                    cpu_insn_ack,
  // Register file
  output cop_isa_pkg::creg_idx_t  rf_raddr1,
  output cop_isa_pkg::creg_idx_t  rf_raddr2,
  input  cop_isa_pkg::cop_word_t  rf_rdata1,
  input  cop_isa_pkg::cop_word_t  rf_rdata2,
  output logic                    rf_wen,
  output cop_isa_pkg::creg_idx_t  rf_waddr,
  output cop_isa_pkg::cop_word_t  rf_wdata,
  // ALU
  output cop_isa_pkg::cop_funct_e alu_funct,
  output cop_isa_pkg::cop_shamt_t alu_shamt,
  output cop_isa_pkg::cop_word_t  alu_opa,
  output cop_isa_pkg::cop_word_t  alu_opb,
  input  cop_isa_pkg::cop_word_t  alu_res
);
  import cop_isa_pkg::*;
  import cop_if_pkg::*;

  ctrl_state_e state;
  cop_word_t   insn_q;  // Instruction under execution
  cop_word_t   rs1_q;
  cop_funct_e  funct;
  cop_result_e res_dec;
  logic        wb_dec;  // Op writes a creg
  logic        wb_q;    // Creg write pending on rsp ack

  assign funct = cop_funct_e'(insn_q[FUNCT3_LO +: $bits(cop_funct_e)]);

  // Opcode first, then funct3
  always_comb begin
    if (insn_q[OPC_LO +: OPC_W] != `COP_OPCODE) begin
      res_dec = RES_NOT_MINE;
    end else begin
      case (funct)
        FN_G2C, FN_C2G, FN_XOR, FN_ADD, FN_ROR, FN_BSWAP: res_dec = RES_OK;
        default:                                          res_dec = RES_ILLEGAL;
      endcase
    end
  end

  assign wb_dec = (res_dec == RES_OK) && (funct != FN_C2G); // C2G goes to GPR only

  // Accept only when free
  assign cop_insn_ack = cpu_insn_req && (state == CS_IDLE);
  assign cop_insn_rsp = (state == CS_RSP);

  // Operand read, straight from the held instruction
  assign rf_raddr1 = insn_q[RS1_LO +: $bits(creg_idx_t)];
  assign rf_raddr2 = insn_q[RS2_LO +: $bits(creg_idx_t)];
  assign alu_funct = funct;
  assign alu_shamt = insn_q[SHAMT_LO +: $bits(cop_shamt_t)];
  assign alu_opa   = (funct == FN_G2C) ? rs1_q : rf_rdata1; // GPR value for G2C
  assign alu_opb   = rf_rdata2;

  // Write-back when the bridge takes the response
  assign rf_wen   = (state == CS_RSP) && cpu_insn_ack && wb_q;
  assign rf_waddr = insn_q[RD_LO +: $bits(creg_idx_t)];
  assign rf_wdata = cop_wdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= CS_IDLE;
      cop_wen    <= 1'b0;
      cop_result <= RES_OK;
      wb_q       <= 1'b0;
    end else begin
      case (state)
        CS_IDLE: begin
          if (cpu_insn_req) begin
            state <= CS_EXEC; // Ack is high this cycle
          end
        end
        CS_EXEC: begin
          cop_result <= res_dec;
          cop_wen    <= (res_dec == RES_OK) && (funct == FN_C2G);
          wb_q       <= wb_dec;
          state      <= CS_RSP;
        end
        CS_RSP: begin
          if (cpu_insn_ack) begin
            wb_q  <= 1'b0;
            state <= CS_IDLE;
          end
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cop_insn_ack) begin
      insn_q <= cpu_insn_enc;
      rs1_q  <= cpu_rs1;
    end
    if (state == CS_EXEC) begin
      cop_wdata <= alu_res; // Held through RSP
    end
  end

endmodule

// File: hdl/pcpi_cop_bridge.sv
module pcpi_cop_bridge (
  input  logic                    clk,
  input  logic                    arst_n,
  // PCPI, CPU side
  input  logic                    pcpi_valid,
  input  cop_isa_pkg::cop_word_t  pcpi_insn,
  input  cop_isa_pkg::cop_word_t  pcpi_rs1,
  input  cop_isa_pkg::cop_word_t  pcpi_rs2,   // No use for rs2 on this path
  output logic                    pcpi_wr,
  output cop_isa_pkg::cop_word_t  pcpi_rd,
  output logic                    pcpi_wait,
  output logic                    pcpi_ready,
  // Instruction request
  output logic                    cpu_insn_req,
  output cop_isa_pkg::cop_word_t  cpu_insn_enc,
  output cop_isa_pkg::cop_word_t  cpu_rs1,
  input  logic                    cop_insn_ack,
  // Response
  input  logic                    cop_wen,
  input  cop_isa_pkg::cop_word_t  cop_wdata,
  input  cop_if_pkg::cop_result_e cop_result,
  input  logic                    cop_insn_rsp,
  output logic                    cpu_insn_ack
);
  import cop_if_pkg::*;

  bridge_state_e state;
  logic          accept;   // New PCPI transaction taken
  logic          rsp_take; // Response seen, acked next cycle
  logic          rsp_ok;

  assign accept   = (state == BS_IDLE) && pcpi_valid;
  assign rsp_take = (state == BS_BUSY) && cop_insn_rsp;
  assign rsp_ok   = (cop_result == RES_OK);

  // CPU stalls while the request is out or the coprocessor works
  assign pcpi_wait = (state == BS_REQ) || (state == BS_BUSY);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= BS_IDLE;
      cpu_insn_req <= 1'b0;
      cpu_insn_ack <= 1'b0;
      pcpi_ready   <= 1'b0;
      pcpi_wr      <= 1'b0;
    end else begin
      cpu_insn_ack <= 1'b0; // One-cycle pulses by default
      pcpi_ready   <= 1'b0;
      pcpi_wr      <= 1'b0;
      case (state)
        BS_IDLE: begin
          if (accept) begin
            cpu_insn_req <= 1'b1; // Exactly one request per transaction
            state        <= BS_REQ;
          end
        end
        BS_REQ: begin
          if (cop_insn_ack) begin
            cpu_insn_req <= 1'b0;
            state        <= BS_BUSY;
          end
        end
        BS_BUSY: begin
          if (rsp_take) begin
            cpu_insn_ack <= 1'b1;
            pcpi_ready   <= rsp_ok; // Rejected: no ready, CPU times out
            pcpi_wr      <= rsp_ok && cop_wen;
            state        <= BS_DONE;
          end
        end
        BS_DONE: state <= BS_HOLD;
        BS_HOLD: begin
          if (!pcpi_valid) begin
            state <= BS_IDLE; // Valid must fall before the next one
          end
        end
        default: state <= BS_IDLE;
      endcase
    end
  end

  // Instruction, rs1 and result word
  always_ff @(posedge clk) begin
    if (accept) begin
      cpu_insn_enc <= pcpi_insn;
      cpu_rs1      <= pcpi_rs1;
    end
    if (rsp_take) begin
      pcpi_rd <= cop_wdata;
    end
  end

endmodule

// File: hdl/pcpi_cop_top.sv
module pcpi_cop_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   pcpi_valid,
  input  cop_isa_pkg::cop_word_t pcpi_insn,
  input  cop_isa_pkg::cop_word_t pcpi_rs1,
  input  cop_isa_pkg::cop_word_t pcpi_rs2,
  output logic                   pcpi_wr,
  output cop_isa_pkg::cop_word_t pcpi_rd,
  output logic                   pcpi_wait,
  output logic                   pcpi_ready
);
  import cop_isa_pkg::*;
  import cop_if_pkg::*;

  // Bridge <-> controller
  logic        cpu_insn_req;
  cop_word_t   cpu_insn_enc;
  cop_word_t   cpu_rs1;
  logic        cop_insn_ack;
  logic        cop_insn_rsp;
  logic        cop_wen;
  cop_word_t   cop_wdata;
  cop_result_e cop_result;
  logic        cpu_insn_ack;

  // Controller <-> datapath
  creg_idx_t   rf_raddr1;
  creg_idx_t   rf_raddr2;
  cop_word_t   rf_rdata1;
  cop_word_t   rf_rdata2;
  logic        rf_wen;
  creg_idx_t   rf_waddr;
  cop_word_t   rf_wdata;
  cop_funct_e  alu_funct;
  cop_shamt_t  alu_shamt;
  cop_word_t   alu_opa;
  cop_word_t   alu_opb;
  cop_word_t   alu_res;

  pcpi_cop_bridge u_bridge (
    .clk          (clk),
    .arst_n       (arst_n),
    .pcpi_valid   (pcpi_valid),
    .pcpi_insn    (pcpi_insn),
    .pcpi_rs1     (pcpi_rs1),
    .pcpi_rs2     (pcpi_rs2),
    .pcpi_wr      (pcpi_wr),
    .pcpi_rd      (pcpi_rd),
    .pcpi_wait    (pcpi_wait),
    .pcpi_ready   (pcpi_ready),
    .cpu_insn_req (cpu_insn_req),
    .cpu_insn_enc (cpu_insn_enc),
    .cpu_rs1      (cpu_rs1),
    .cop_insn_ack (cop_insn_ack),
    .cop_wen      (cop_wen),
    .cop_wdata    (cop_wdata),
    .cop_result   (cop_result),
    .cop_insn_rsp (cop_insn_rsp),
    .cpu_insn_ack (cpu_insn_ack)
  );

  cop_ctrl u_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .cpu_insn_req (cpu_insn_req),
    .cpu_insn_enc (cpu_insn_enc),
    .cpu_rs1      (cpu_rs1),
    .cop_insn_ack (cop_insn_ack),
    .cop_insn_rsp (cop_insn_rsp),
    .cop_wen      (cop_wen),
    .cop_wdata    (cop_wdata),
    .cop_result   (cop_result),
    .cpu_insn_ack (cpu_insn_ack),
    .rf_raddr1    (rf_raddr1),
    .rf_raddr2    (rf_raddr2),
    .rf_rdata1    (rf_rdata1),
    .rf_rdata2    (rf_rdata2),
    .rf_wen       (rf_wen),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .alu_funct    (alu_funct),
    .alu_shamt    (alu_shamt),
    .alu_opa      (alu_opa),
    .alu_opb      (alu_opb),
    .alu_res      (alu_res)
  );

  cop_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  cop_alu u_alu (
    .funct (alu_funct),
    .shamt (alu_shamt),
    .opa   (alu_opa),
    .opb   (alu_opb),
    .res   (alu_res)
  );

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // Two full cycles in reset, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: tests/tb_pcpi_cop.sv
module tb_pcpi_cop;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PCPI_TIMEOUT  = 16; // CPU gives up after this many cycles
  localparam int RESET_TIMEOUT = 10;
  localparam int READY_LATENCY = 3;  // Rising edges from accept to ready

  logic        clk;
  logic        arst_n;
  logic        pcpi_valid;
  logic [31:0] pcpi_insn;
  logic [31:0] pcpi_rs1;
  logic [31:0] pcpi_rs2;
  logic        pcpi_wr;
  logic [31:0] pcpi_rd;
  logic        pcpi_wait;
  logic        pcpi_ready;

  int n_errors;
  int n_checks;
  int n_insns;

  tb_clock_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  pcpi_cop_top u_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .pcpi_valid (pcpi_valid),
    .pcpi_insn  (pcpi_insn),
    .pcpi_rs1   (pcpi_rs1),
    .pcpi_rs2   (pcpi_rs2),
    .pcpi_wr    (pcpi_wr),
    .pcpi_rd    (pcpi_rd),
    .pcpi_wait  (pcpi_wait),
    .pcpi_ready (pcpi_ready)
  );

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    n_checks++;
    if (actual !== expected) begin // X counts as wrong
      n_errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t",
               name, actual, expected, $time);
    end
  endtask

  // Ends on a falling edge with reset released
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1) begin
      n_errors++;
      $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
    end
  endtask

  // CPU side of one PCPI transaction
  // Entered and left on a falling edge
  task automatic run_insn(input logic [31:0] insn, input logic [31:0] rs1,
                          input logic exp_ready, input logic exp_wr,
                          input logic [31:0] exp_rd);
    int   cycles;
    logic seen;
    cycles     = 0;
    seen       = 1'b0;
    pcpi_valid = 1'b1;
    pcpi_insn  = insn;
    pcpi_rs1   = rs1;
    pcpi_rs2   = $urandom; // Ignored by the DUT
    while (!seen && cycles < PCPI_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (pcpi_ready === 1'b1) begin
        seen = 1'b1;
      end else if (exp_ready && cycles <= READY_LATENCY) begin
        compare_value("pcpi_wait", pcpi_wait, 1'b1); // CPU stalled until ready
      end
    end
    if (seen) begin
      if (!exp_ready) begin
        compare_value("pcpi_ready", pcpi_ready, 1'b0); // Rejected insn must time out
      end
      compare_value("ready_latency", cycles - 1, READY_LATENCY);
      compare_value("pcpi_wait", pcpi_wait, 1'b0);
      compare_value("pcpi_wr", pcpi_wr, exp_wr);
      if (exp_wr) begin
        compare_value("pcpi_rd", pcpi_rd, exp_rd);
      end
      @(negedge clk);
      compare_value("pcpi_ready", pcpi_ready, 1'b0); // Single pulse
    end else if (exp_ready) begin
      n_errors++;
      $display("No pcpi_ready within %0d cycles for instruction 0x%08h",
               PCPI_TIMEOUT, insn);
    end
    pcpi_valid = 1'b0; // Dropped in the cycle after ready or at the CPU timeout
  endtask

  initial begin
    int          fd;
    int          n_fields;
    int          gap;
    string       line;
    logic [31:0] insn;
    logic [31:0] rs1;
    logic [31:0] exp_rd;
    logic        exp_ready;
    logic        exp_wr;
    gap        = $urandom(32'h71421c32); // Seeds the generator
    n_errors   = 0;
    n_checks   = 0;
    n_insns    = 0;
    pcpi_valid = 1'b0;
    pcpi_insn  = '0;
    pcpi_rs1   = '0;
    pcpi_rs2   = '0;
    wait_reset_release();
    fd = $fopen("tests/pcpi_cop_trace.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("Cannot open trace file tests/pcpi_cop_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line     = "";
        n_fields = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin // Skip comments and blanks
          n_fields = $sscanf(line, "%h %h %h %h %h",
                             insn, rs1, exp_ready, exp_wr, exp_rd);
          if (n_fields != 5) begin
            n_errors++;
            $display("Malformed trace line: %s", line);
          end else begin
            @(negedge clk); // Valid low for at least one cycle
            gap = $urandom_range(3, 0);
            repeat (gap) @(negedge clk);
            run_insn(insn, rs1, exp_ready, exp_wr, exp_rd);
            n_insns++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_insns == 0) begin
      n_errors++;
      $display("No instructions were read from the trace");
    end
    $display("Instructions: %0d, checks: %0d, errors: %0d", n_insns, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: pcpi_cop.f
+incdir+hdl
hdl/cop_isa_pkg.sv
hdl/cop_if_pkg.sv
hdl/cop_alu.sv
hdl/cop_regfile.sv
hdl/cop_ctrl.sv
hdl/pcpi_cop_bridge.sv
hdl/pcpi_cop_top.sv
tests/tb_clock_gen.sv
tests/tb_pcpi_cop.sv

// File: tests/pcpi_cop_trace.txt
# PCPI trace, one instruction per line, all fields in hex
# insn rs1 exp_ready exp_wr exp_rd (exp_rd checked only when exp_wr is 1)
0000150B 00000000 1 1 00000000
0002150B 00000000 1 1 00000000
0004950B 00000000 1 1 00000000
0007950B 00000000 1 1 00000000
0000008B 12345678 1 0 00000000
0000950B 00000000 1 1 12345678
0000010B 0F0F00FF 1 0 00000000
0000028B FFFFFFF0 1 0 00000000
0020A18B 00000000 1 0 00000000
0001950B 00000000 1 1 1D3B5687
0020B20B 00000000 1 0 00000000
0002150B 00000000 1 1 21435777
0012B30B 00000000 1 0 00000000
0013330B 00000000 1 0 00000000
0003150B 00000000 1 1 2468ACE0
1000C38B 00000000 1 0 00000000
0003950B 00000000 1 1 78123456
0000C40B 00000000 1 0 00000000
0004150B 00000000 1 1 12345678
3E02C50B 00000000 1 0 00000000
0005150B 00000000 1 1 FFFFFFE1
0000D58B 00000000 1 0 00000000
0005950B 00000000 1 1 78563412
00000633 DEADBEEF 0 0 00000000
0000660B DEADBEEF 0 0 00000000
0000708B DEADBEEF 0 0 00000000
0006150B 00000000 1 1 00000000
0000950B 00000000 1 1 12345678
